//--- files.f
source/game_pkg.sv
source/vga_timing.sv
source/draw_map.sv
source/draw_door.sv
source/draw_interface.sv
source/draw_obj.sv
source/game_display.sv
source/game_video_top.sv
verif/game_video_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the video path testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module game_video_tb -f files.f -o game_video_sim

./obj_dir/game_video_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported failures."
    exit 1
fi
echo "Simulation finished without failures."

//--- verif/game_video_tb.sv
// Self-checking testbench for the maze game video path; run it through files.f with Verilator.
module game_video_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CLKS     = 800 * 525;
    localparam int NUM_FRAMES     = 6;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CLKS + 1000;

    logic        clk;
    logic        rst;
    logic [3:0]  state;
    logic [3:0]  play_valid;
    logic        is_locked;
    logic        key_find;
    logic [1:0]  heart;
    logic [16:0] pixel_addr;
    logic        not_blank;
    logic        hsync;
    logic        vsync;

    int          m_h;         // Model pixel counter.
    int          m_v;         // Model line counter.
    logic [17:0] pix;         // Hit flag above the address.
    logic [16:0] exp_addr;
    logic        exp_nb;
    logic        exp_hs;
    logic        exp_vs;
    logic        exp_border;  // Last pixel lay outside 640x480.
    int          err_cnt = 0;
    int          sync_err = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          frames = 0;
    int          cycle_cnt = 0;
    integer      seed = 32'hd11e7675;
    logic [3:0]  blank_states [7];

    game_video_top UUT (
        .clk(clk), .rst(rst), .state(state), .play_valid(play_valid),
        .is_locked(is_locked), .key_find(key_find), .heart(heart),
        .pixel_addr(pixel_addr), .not_blank(not_blank), .hsync(hsync), .vsync(vsync)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ///////////////////////////////////////////////////////////////////////
    // Reference pixel model built from the screen layout.
    ///////////////////////////////////////////////////////////////////////
    function automatic logic [17:0] ref_pixel(input logic [3:0] st, input int h, input int v,
                                              input logic [3:0] pv, input logic [1:0] hr,
                                              input logic lk, input logic kf);
        int slot;
        if (h >= 640 || v >= 480) return '0;
        if (st == game_pkg::TITLE) begin
            if (v >= 320 && v < 352 && h >= 96) begin
                slot = (h - 96) / 128;
                if (slot < 4 && (h - 96) % 128 < 64 && pv[slot[1:0]])
                    return {1'b1, 17'(game_pkg::BUTTON_BASE + 2048 * slot +
                                      (h - 96) % 128 + 64 * (v - 320))};
            end
            return '0;
        end
        if (st != game_pkg::STAGE1) return '0;
        if (v < 32 && h >= 16 && (h - 16) / 32 < int'(hr))
            return {1'b1, 17'(game_pkg::ICON_BASE + (h - 16) % 32 + 32 * v)};
        if (v < 32 && kf && h >= 576 && h < 608)
            return {1'b1, 17'(game_pkg::ICON_BASE + 1024 + (h - 576) + 32 * v)};
        if (!kf && h >= 256 && h < 288 && v >= 240 && v < 272)
            return {1'b1, 17'(game_pkg::KEY_BASE + (h - 256) + 32 * (v - 240))};
        if (h < 512 && v >= 32)
            return {1'b1, 17'(game_pkg::MAP_BASE + h / 2 + 256 * ((v - 32) / 2))};
        if (h >= 544 && h < 608 && v >= 224 && v < 288)
            return {1'b1, 17'(game_pkg::DOOR_BASE + (lk ? 0 : 4096) + (h - 544) +
                              64 * (v - 224))};
        return '0;
    endfunction

    assign pix = ref_pixel(state, m_h, m_v, play_valid, heart, is_locked, key_find);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_h        <= 0;
            m_v        <= 0;
            exp_addr   <= '0;
            exp_nb     <= 1'b0;
            exp_hs     <= 1'b1;
            exp_vs     <= 1'b1;
            exp_border <= 1'b1;
        end else begin
            exp_nb     <= pix[17];
            exp_addr   <= pix[16:0];
            exp_hs     <= !(m_h >= 656 && m_h <= 751);
            exp_vs     <= !(m_v >= 490 && m_v <= 491);
            exp_border <= (m_h >= 640) || (m_v >= 480);
            if (m_h == 799) begin
                m_h <= 0;
                m_v <= (m_v == 524) ? 0 : m_v + 1;  // Frame wraps after line 524.
            end else begin
                m_h <= m_h + 1;
            end
        end
    end

    // New frame settings are picked at each frame start.
    always @(posedge clk) begin
        if (!rst && m_h == 0 && m_v == 0) begin
            frames     <= frames + 1;
            play_valid <= 4'($random(seed));
            heart      <= 2'($random(seed));
            key_find   <= frames[0];   // The two stage frames see both key cases.
            is_locked  <= !frames[0];
            if (frames < 2) begin
                state <= game_pkg::TITLE;
            end else if (frames < 4) begin
                state <= game_pkg::STAGE1;
            end else begin
                state <= blank_states[3'($unsigned($random(seed)) % 7)];
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Checks
    ///////////////////////////////////////////////////////////////////////
    check_addr: assert property (@(posedge clk) pixel_addr == exp_addr)
        else begin
            $display("error at %0t: pixel_addr is %0d, expected %0d",
                     $time, $sampled(pixel_addr), $sampled(exp_addr));
            err_cnt++;
        end

    check_nb: assert property (@(posedge clk) not_blank == exp_nb)
        else begin
            $display("error at %0t: not_blank is %0b, expected %0b",
                     $time, $sampled(not_blank), $sampled(exp_nb));
            err_cnt++;
        end

    check_hsync: assert property (@(posedge clk) hsync == exp_hs)
        else begin
            $display("error at %0t: hsync is %0b, expected %0b",
                     $time, $sampled(hsync), $sampled(exp_hs));
            err_cnt++;
            sync_err++;
        end

    check_vsync: assert property (@(posedge clk) vsync == exp_vs)
        else begin
            $display("error at %0t: vsync is %0b, expected %0b",
                     $time, $sampled(vsync), $sampled(exp_vs));
            err_cnt++;
            sync_err++;
        end

    check_border: assert property (@(posedge clk) exp_border |-> (!not_blank && pixel_addr == '0))
        else begin
            $display("At %0t a pixel outside the visible area was not blank.", $time);
            err_cnt++;
            sync_err++;
        end

    task automatic report_test(input string name, input int fails);
        if (fails == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", name, fails);
        end
    endtask

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("The run did not finish within %0d cycles.", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main_seq
        int mark;
        rst          = 1'b1;
        state        = game_pkg::TITLE;
        play_valid   = 4'd0;
        is_locked    = 1'b1;
        key_find     = 1'b0;
        heart        = 2'd0;
        blank_states = '{game_pkg::STAFF, game_pkg::SUCCESS1, game_pkg::STAGE2,
                         game_pkg::SUCCESS2, game_pkg::STAGE3, game_pkg::SUCCESS3,
                         game_pkg::FAIL};
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);  // Outputs must still be idle one cycle after reset.
        @(negedge clk);
        report_test("reset", err_cnt);
        mark = err_cnt;
        wait (frames == 3);
        @(negedge clk);
        report_test("title screen", err_cnt - mark);
        mark = err_cnt;
        wait (frames == 5);
        @(negedge clk);
        report_test("stage 1", err_cnt - mark);
        mark = err_cnt;
        wait (frames == 7);
        @(negedge clk);
        report_test("blank states", err_cnt - mark);
        report_test("sync and border", sync_err);
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- source/game_video_top.sv
// Video path top: timing, the four layer drawers and the display register for the maze game.
module game_video_top #(
    parameter int H_FRONT = game_pkg::H_FRONT,
    parameter int H_SYNC  = game_pkg::H_SYNC,
    parameter int H_BACK  = game_pkg::H_BACK,
    parameter int V_FRONT = game_pkg::V_FRONT,
    parameter int V_SYNC  = game_pkg::V_SYNC,
    parameter int V_BACK  = game_pkg::V_BACK
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [3:0]                    state,
    input  logic [3:0]                    play_valid,
    input  logic                          is_locked,
    input  logic                          key_find,
    input  logic [1:0]                    heart,
    output logic [game_pkg::ADDR_W-1:0]   pixel_addr,
    output logic                          not_blank,
    output logic                          hsync,
    output logic                          vsync
);

    logic [game_pkg::CNT_W-1:0]  h_cnt;
    logic [game_pkg::CNT_W-1:0]  v_cnt;
    logic                        active;
    logic                        hsync_raw;  // Unregistered syncs.
    logic                        vsync_raw;
    logic                        map_hit;
    logic                        door_hit;
    logic                        ui_hit;
    logic                        obj_hit;
    logic [game_pkg::ADDR_W-1:0] map_addr;
    logic [game_pkg::ADDR_W-1:0] door_addr;
    logic [game_pkg::ADDR_W-1:0] ui_addr;
    logic [game_pkg::ADDR_W-1:0] obj_addr;

    vga_timing #(
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .clk(clk), .rst(rst), .h_cnt(h_cnt), .v_cnt(v_cnt),
        .active(active), .hsync(hsync_raw), .vsync(vsync_raw)
    );

    draw_map u_map (
        .state(state), .h_cnt(h_cnt), .v_cnt(v_cnt),
        .map_hit(map_hit), .map_addr(map_addr)
    );

    draw_door u_door (
        .state(state), .h_cnt(h_cnt), .v_cnt(v_cnt), .is_locked(is_locked),
        .door_hit(door_hit), .door_addr(door_addr)
    );

    draw_interface u_ui (
        .state(state), .h_cnt(h_cnt), .v_cnt(v_cnt), .key_find(key_find),
        .heart(heart), .play_valid(play_valid), .ui_hit(ui_hit), .ui_addr(ui_addr)
    );

    draw_obj u_obj (
        .state(state), .h_cnt(h_cnt), .v_cnt(v_cnt), .key_find(key_find),
        .obj_hit(obj_hit), .obj_addr(obj_addr)
    );

    game_display u_display (
        .clk(clk), .rst(rst), .state(state), .active(active),
        .hsync_in(hsync_raw), .vsync_in(vsync_raw),
        .map_hit(map_hit), .map_addr(map_addr), .door_hit(door_hit), .door_addr(door_addr),
        .ui_hit(ui_hit), .ui_addr(ui_addr), .obj_hit(obj_hit), .obj_addr(obj_addr),
        .pixel_addr(pixel_addr), .not_blank(not_blank), .hsync(hsync), .vsync(vsync)
    );

endmodule

//--- source/game_display.sv
// Output stage: picks one layer per state and priority, blanks, and registers with the syncs.
module game_display (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [3:0]                    state,
    input  logic                          active,
    input  logic                          hsync_in,
    input  logic                          vsync_in,
    input  logic                          map_hit,
    input  logic [game_pkg::ADDR_W-1:0]   map_addr,
    input  logic                          door_hit,
    input  logic [game_pkg::ADDR_W-1:0]   door_addr,
    input  logic                          ui_hit,
    input  logic [game_pkg::ADDR_W-1:0]   ui_addr,
    input  logic                          obj_hit,
    input  logic [game_pkg::ADDR_W-1:0]   obj_addr,
    output logic [game_pkg::ADDR_W-1:0]   pixel_addr,
    output logic                          not_blank,
    output logic                          hsync,
    output logic                          vsync
);

    logic [game_pkg::ADDR_W-1:0] sel_addr;
    logic                        sel_hit;

    //////////////////////////////////////////////////////////////////////
    // Layer select
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        sel_hit  = 1'b0;
        sel_addr = '0;
        case (state)
            game_pkg::TITLE: begin
                if (ui_hit) begin
                    sel_hit  = 1'b1;
                    sel_addr = ui_addr;
                end
            end
            game_pkg::STAGE1: begin
                // Interface on top, the door at the back.
                if (ui_hit) begin
                    sel_hit  = 1'b1;
                    sel_addr = ui_addr;
                end else if (obj_hit) begin
                    sel_hit  = 1'b1;
                    sel_addr = obj_addr;
                end else if (map_hit) begin
                    sel_hit  = 1'b1;
                    sel_addr = map_addr;
                end else if (door_hit) begin
                    sel_hit  = 1'b1;
                    sel_addr = door_addr;
                end
            end
            default: begin
                sel_hit = 1'b0;  // Remaining screens are not drawn yet.
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_addr <= '0;
            not_blank  <= 1'b0;
            hsync      <= 1'b1;
            vsync      <= 1'b1;
        end else begin
            not_blank  <= active && sel_hit;
            pixel_addr <= (active && sel_hit) ? sel_addr : '0;  // Blank pixels read word 0.
            hsync      <= hsync_in;
            vsync      <= vsync_in;
        end
    end

endmodule

//--- source/draw_obj.sv
// Object layer: the collectible key lying in the maze until the player picks it up.
module draw_obj (
    input  logic [3:0]                    state,
    input  logic [game_pkg::CNT_W-1:0]    h_cnt,
    input  logic [game_pkg::CNT_W-1:0]    v_cnt,
    input  logic                          key_find,
    output logic                          obj_hit,
    output logic [game_pkg::ADDR_W-1:0]   obj_addr
);

    localparam int AW = game_pkg::ADDR_W;

    logic [game_pkg::CNT_W-1:0] col;
    logic [game_pkg::CNT_W-1:0] row;
    logic                       in_key;

    assign col = h_cnt - game_pkg::MKEY_X0;
    assign row = v_cnt - game_pkg::MKEY_Y0;

    assign in_key = (h_cnt >= game_pkg::MKEY_X0) &&
                    (h_cnt < game_pkg::MKEY_X0 + game_pkg::ICON_SIZE) &&
                    (v_cnt >= game_pkg::MKEY_Y0) &&
                    (v_cnt < game_pkg::MKEY_Y0 + game_pkg::ICON_SIZE);

    // Gone from the maze once found.
    assign obj_hit = (state == game_pkg::STAGE1) && !key_find && in_key;

    assign obj_addr = game_pkg::KEY_BASE + AW'({row[4:0], col[4:0]});  // 32x32 image.

endmodule

//--- source/draw_interface.sv
// Interface layer: heart bar and key icon in STAGE1, stage select buttons on the title screen.
module draw_interface (
    input  logic [3:0]                    state,
    input  logic [game_pkg::CNT_W-1:0]    h_cnt,
    input  logic [game_pkg::CNT_W-1:0]    v_cnt,
    input  logic                          key_find,
    input  logic [1:0]                    heart,
    input  logic [3:0]                    play_valid,
    output logic                          ui_hit,
    output logic [game_pkg::ADDR_W-1:0]   ui_addr
);

    localparam int AW = game_pkg::ADDR_W;

    logic [game_pkg::CNT_W-1:0] heart_x;  // Column from the first heart.
    logic [game_pkg::CNT_W-1:0] btn_x;    // Column from the first button.
    logic [game_pkg::CNT_W-1:0] btn_y;
    logic [1:0]                 heart_slot;
    logic [1:0]                 btn_slot;
    logic                       in_bar;
    logic                       heart_hit;
    logic                       key_hit;
    logic                       btn_hit;

    //////////////////////////////////////////////////////////////////////
    // Slot decode
    //////////////////////////////////////////////////////////////////////
    assign heart_x    = h_cnt - game_pkg::HEART_X0;
    assign heart_slot = heart_x[6:5];  // 32 columns per heart.
    assign btn_x      = h_cnt - game_pkg::BTN_X0;
    assign btn_y      = v_cnt - game_pkg::BTN_Y0;
    assign btn_slot   = btn_x[8:7];    // 128 columns per button slot.

    assign in_bar = (state == game_pkg::STAGE1) && (v_cnt < game_pkg::BAR_H);

    assign heart_hit = in_bar && (h_cnt >= game_pkg::HEART_X0) &&
                       (h_cnt < game_pkg::HEART_X_END) && (heart_slot < heart);

    assign key_hit = in_bar && key_find && (h_cnt >= game_pkg::KEY_ICON_X0) &&
                     (h_cnt < game_pkg::KEY_ICON_X0 + game_pkg::ICON_SIZE);

    // Only the left 64 columns of each slot hold a button.
    assign btn_hit = (state == game_pkg::TITLE) &&
                     (h_cnt >= game_pkg::BTN_X0) && (h_cnt < game_pkg::BTN_X_END) &&
                     !btn_x[6] && play_valid[btn_slot] &&
                     (v_cnt >= game_pkg::BTN_Y0) &&
                     (v_cnt < game_pkg::BTN_Y0 + game_pkg::BTN_H);

    assign ui_hit = heart_hit || key_hit || btn_hit;

    //////////////////////////////////////////////////////////////////////
    // Address
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        if (btn_hit) begin
            // Each button takes 2048 words and is 64 wide.
            ui_addr = game_pkg::BUTTON_BASE + AW'({btn_slot, btn_y[4:0], btn_x[5:0]});
        end else if (key_hit) begin
            ui_addr = game_pkg::ICON_BASE + game_pkg::KEY_ICON_OFS +
                      AW'({v_cnt[4:0], h_cnt[4:0]});  // Icon starts on a 32 boundary.
        end else begin
            ui_addr = game_pkg::ICON_BASE + AW'({v_cnt[4:0], heart_x[4:0]});
        end
    end

endmodule

//--- source/draw_door.sv
// Door layer: draws the exit door in STAGE1 using its locked or open image.
module draw_door (
    input  logic [3:0]                    state,
    input  logic [game_pkg::CNT_W-1:0]    h_cnt,
    input  logic [game_pkg::CNT_W-1:0]    v_cnt,
    input  logic                          is_locked,
    output logic                          door_hit,
    output logic [game_pkg::ADDR_W-1:0]   door_addr
);

    localparam int AW = game_pkg::ADDR_W;

    logic [game_pkg::CNT_W-1:0] col;
    logic [game_pkg::CNT_W-1:0] row;
    logic                       in_door;
    logic [AW-1:0]              img_base;

    assign col = h_cnt - game_pkg::DOOR_X0;
    assign row = v_cnt - game_pkg::DOOR_Y0;

    assign in_door = (h_cnt >= game_pkg::DOOR_X0) &&
                     (h_cnt < game_pkg::DOOR_X0 + game_pkg::DOOR_SIZE) &&
                     (v_cnt >= game_pkg::DOOR_Y0) &&
                     (v_cnt < game_pkg::DOOR_Y0 + game_pkg::DOOR_SIZE);

    assign door_hit = (state == game_pkg::STAGE1) && in_door;

    // The open image follows the locked one in the sheet.
    assign img_base = is_locked ? game_pkg::DOOR_BASE
                                : game_pkg::DOOR_BASE + game_pkg::DOOR_OPEN_OFS;

    // The image is 64 wide, so the row sits above the six column bits.
    assign door_addr = img_base + AW'({row[5:0], col[5:0]});

endmodule

//--- source/draw_map.sv
// Map layer: covers the playfield in STAGE1 and indexes the half-resolution map image.
module draw_map (
    input  logic [3:0]                    state,
    input  logic [game_pkg::CNT_W-1:0]    h_cnt,
    input  logic [game_pkg::CNT_W-1:0]    v_cnt,
    output logic                          map_hit,
    output logic [game_pkg::ADDR_W-1:0]   map_addr
);

    localparam int AW = game_pkg::ADDR_W;

    logic [game_pkg::CNT_W-1:0] row;  // Line offset from the top of the map.
    logic                       in_map;
    logic [AW-1:0]              col_ofs;
    logic [AW-1:0]              row_ofs;

    assign row = v_cnt - game_pkg::MAP_Y0;

    assign in_map = (h_cnt < game_pkg::MAP_X_END) &&
                    (v_cnt >= game_pkg::MAP_Y0) &&
                    (v_cnt < game_pkg::V_ACTIVE);

    assign map_hit = (state == game_pkg::STAGE1) && in_map;

    // Each map texel covers a 2x2 block of screen pixels.
    assign col_ofs  = AW'(h_cnt[game_pkg::CNT_W-1:1]);
    assign row_ofs  = AW'(row[game_pkg::CNT_W-1:1]) << 8;  // 256 texels per map row.
    assign map_addr = game_pkg::MAP_BASE + col_ofs + row_ofs;

endmodule

//--- source/vga_timing.sv
// VGA timing generator: pixel and line counters with sync and active-area decode.
module vga_timing #(
    parameter int H_FRONT = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 48,
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic [game_pkg::CNT_W-1:0]  h_cnt,
    output logic [game_pkg::CNT_W-1:0]  v_cnt,
    output logic                        active,
    output logic                        hsync,
    output logic                        vsync
);

    localparam int CW = game_pkg::CNT_W;

    localparam int H_TOTAL = game_pkg::H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = game_pkg::V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam logic [CW-1:0] H_LAST   = CW'(H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST   = CW'(V_TOTAL - 1);
    localparam logic [CW-1:0] H_VIS    = CW'(game_pkg::H_ACTIVE);
    localparam logic [CW-1:0] V_VIS    = CW'(game_pkg::V_ACTIVE);
    localparam logic [CW-1:0] HS_START = CW'(game_pkg::H_ACTIVE + H_FRONT);
    localparam logic [CW-1:0] HS_END   = CW'(game_pkg::H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [CW-1:0] VS_START = CW'(game_pkg::V_ACTIVE + V_FRONT);
    localparam logic [CW-1:0] VS_END   = CW'(game_pkg::V_ACTIVE + V_FRONT + V_SYNC);

    logic h_wrap;

    assign h_wrap = (h_cnt == H_LAST);  // Last clock of the line.

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_wrap) begin
                h_cnt <= '0;
                if (v_cnt == V_LAST) begin
                    v_cnt <= '0;  // End of frame.
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////
    assign active = (h_cnt < H_VIS) && (v_cnt < V_VIS);
    assign hsync  = !((h_cnt >= HS_START) && (h_cnt < HS_END));  // Sync pulses are low.
    assign vsync  = !((v_cnt >= VS_START) && (v_cnt < VS_END));

endmodule

//--- source/game_pkg.sv
// Shared state codes, screen geometry and sprite-sheet bases for the video path and its testbench.
package game_pkg;

    //////////////////////////////////////////////////////////////////////
    // Game states, as driven by the game FSM.
    //////////////////////////////////////////////////////////////////////
    localparam logic [3:0] TITLE    = 4'd0;
    localparam logic [3:0] STAFF    = 4'd1;
    localparam logic [3:0] STAGE1   = 4'd2;
    localparam logic [3:0] SUCCESS1 = 4'd3;
    localparam logic [3:0] STAGE2   = 4'd4;
    localparam logic [3:0] SUCCESS2 = 4'd5;
    localparam logic [3:0] STAGE3   = 4'd6;
    localparam logic [3:0] SUCCESS3 = 4'd7;
    localparam logic [3:0] FAIL     = 4'd8;

    localparam int CNT_W  = 10;  // Pixel and line counter width.
    localparam int ADDR_W = 17;  // 320x240 sprite sheet needs 76800 words.

    //////////////////////////////////////////////////////////////////////
    // 640x480 VGA timing.
    //////////////////////////////////////////////////////////////////////
    localparam int H_ACTIVE = 640;
    localparam int V_ACTIVE = 480;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

    //////////////////////////////////////////////////////////////////////
    // Sprite sheet layout.
    //////////////////////////////////////////////////////////////////////
    localparam logic [ADDR_W-1:0] MAP_BASE      = 17'd0;      // 256x224 map image.
    localparam logic [ADDR_W-1:0] DOOR_BASE     = 17'd57344;  // Locked then open door.
    localparam logic [ADDR_W-1:0] DOOR_OPEN_OFS = 17'd4096;
    localparam logic [ADDR_W-1:0] ICON_BASE     = 17'd65536;  // Heart then key icon.
    localparam logic [ADDR_W-1:0] KEY_ICON_OFS  = 17'd1024;
    localparam logic [ADDR_W-1:0] BUTTON_BASE   = 17'd67584;  // One 64x32 button per stage.
    localparam logic [ADDR_W-1:0] KEY_BASE      = 17'd75776;  // Key lying in the maze.

    // Screen placement of each layer, in counter units.
    localparam logic [CNT_W-1:0] MAP_X_END   = 10'd512;
    localparam logic [CNT_W-1:0] MAP_Y0      = 10'd32;
    localparam logic [CNT_W-1:0] DOOR_X0     = 10'd544;
    localparam logic [CNT_W-1:0] DOOR_Y0     = 10'd224;
    localparam logic [CNT_W-1:0] DOOR_SIZE   = 10'd64;
    localparam logic [CNT_W-1:0] BAR_H       = 10'd32;
    localparam logic [CNT_W-1:0] HEART_X0    = 10'd16;
    localparam logic [CNT_W-1:0] HEART_X_END = 10'd112;  // Room for three hearts.
    localparam logic [CNT_W-1:0] ICON_SIZE   = 10'd32;
    localparam logic [CNT_W-1:0] KEY_ICON_X0 = 10'd576;
    localparam logic [CNT_W-1:0] BTN_X0      = 10'd96;
    localparam logic [CNT_W-1:0] BTN_X_END   = 10'd608;  // Four slots of 128 columns.
    localparam logic [CNT_W-1:0] BTN_Y0      = 10'd320;
    localparam logic [CNT_W-1:0] BTN_H       = 10'd32;
    localparam logic [CNT_W-1:0] MKEY_X0     = 10'd256;
    localparam logic [CNT_W-1:0] MKEY_Y0     = 10'd240;

endpackage
